// File: common/synth_pkg.sv
package synth_pkg;

	// ********************
	// widths
	// ********************

	localparam int phase_bits = 16;  // per-voice phase accumulator
	localparam int wave_bits = 8;    // phase bits seen by the waveform shaper

	typedef logic [11:0] sample_t;

	// ********************
	// MIDI
	// ********************

	localparam logic [3:0] status_note_off = 4'h8;
	localparam logic [3:0] status_note_on = 4'h9;
	localparam logic [3:0] status_control = 4'hb;

	localparam int sustain_controller = 64;
	localparam int sustain_threshold = 64;  // pedal counts as down from this value up

	typedef enum logic [1:0] {
		msg_none,
		msg_note_on,
		msg_note_off,
		msg_control
	} midi_kind_e;

	// value carries the velocity for notes and the controller value otherwise
	typedef struct packed {
		midi_kind_e kind;
		logic [6:0] note;
		logic [6:0] value;
	} midi_msg_t;

	// ********************
	// voices and waves
	// ********************

	typedef enum logic [1:0] {
		wave_square,
		wave_saw,
		wave_triangle
	} wave_mode_e;

	typedef struct packed {
		logic active;
		logic [wave_bits-1:0] phase;  // top bits of the accumulator
		logic [6:0] velocity;
	} voice_t;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int clks_per_bit = 16
) (
	input logic MHz10,
	input logic nrst,
	input logic en,
	input logic ser_in,
	output logic [7:0] data,
	output logic done
);
	localparam int cnt_bits = (clks_per_bit > 2) ? $clog2(clks_per_bit) : 1;
	localparam logic [cnt_bits-1:0] last_cnt = cnt_bits'(clks_per_bit - 1);
	localparam logic [cnt_bits-1:0] half_cnt = cnt_bits'(clks_per_bit / 2 - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync;
	logic rx;
	logic [cnt_bits-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic sample_bit;

	assign rx = rx_sync[1];
	assign sample_bit = (state == st_data) && (baud_cnt == last_cnt);

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			rx_sync <= 2'b11;  // line idles high
			state <= st_idle;
			baud_cnt <= '0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else if (en) begin
			rx_sync <= {rx_sync[0], ser_in};
			done <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				st_idle: begin
					baud_cnt <= '0;
					if (!rx)
						state <= st_start;
				end
				st_start: begin
					// recheck the start bit halfway through so that a glitch is ignored
					if (baud_cnt == half_cnt) begin
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= rx ? st_idle : st_data;
					end
				end
				st_data: begin
					if (baud_cnt == last_cnt) begin
						baud_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= st_stop;
					end
				end
				default: begin
					if (baud_cnt == last_cnt) begin
						done <= rx;  // a frame with a bad stop bit is dropped
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// LSB arrives first, so bits shift in from the top
	always_ff @(posedge MHz10) begin
		if (en && sample_bit)
			data <= {rx, data[7:1]};
	end

endmodule

// File: midi/midi_decoder.sv
`timescale 1ns/1ps

module midi_decoder import synth_pkg::*; (
	input logic MHz10,
	input logic nrst,
	input logic en,
	input logic [7:0] data,
	input logic done,
	output midi_msg_t msg,
	output logic msg_valid
);
	typedef enum logic [1:0] {
		wait_status,
		first_data,
		second_data
	} parse_state_e;

	parse_state_e state;
	logic [3:0] status_q;  // message type nibble of the last status byte
	logic [6:0] note_q;
	logic is_status;
	logic known_status;
	midi_kind_e kind_next;

	assign is_status = data[7];

	always_comb begin
		known_status = (data[7:4] == status_note_off) ||
			(data[7:4] == status_note_on) ||
			(data[7:4] == status_control);
	end

	// ********************
	// message classification
	// ********************

	always_comb begin
		case (status_q)
			status_note_on: begin
				// velocity 0 is the usual way to release a note
				kind_next = (data[6:0] == 7'd0) ? msg_note_off : msg_note_on;
			end
			status_note_off: kind_next = msg_note_off;
			status_control: kind_next = msg_control;
			default: kind_next = msg_none;
		endcase
	end

	// ********************
	// byte parser
	// ********************

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			state <= wait_status;
			status_q <= '0;
			note_q <= '0;
			msg <= '0;
			msg_valid <= 1'b0;
		end else if (en) begin
			msg_valid <= 1'b0;
			if (done) begin
				if (is_status) begin
					status_q <= data[7:4];
					// unsupported messages are skipped until the next status byte
					state <= known_status ? first_data : wait_status;
				end else begin
					case (state)
						first_data: begin
							note_q <= data[6:0];
							state <= second_data;
						end
						second_data: begin
							msg <= '{kind: kind_next, note: note_q, value: data[6:0]};
							msg_valid <= 1'b1;
							state <= wait_status;  // no running status
						end
						default: begin
							state <= wait_status;  // stray data byte
						end
					endcase
				end
			end
		end
	end

endmodule

// File: voice/voice_bank.sv
`timescale 1ns/1ps

module voice_bank import synth_pkg::*; #(
	parameter int n_voices = 8
) (
	input logic MHz10,
	input logic nrst,
	input logic en,
	input logic clear,
	input midi_msg_t msg,
	input logic msg_valid,
	input logic phase_step,
	output voice_t [n_voices-1:0] voices
);
	localparam int idx_bits = (n_voices > 1) ? $clog2(n_voices) : 1;

	typedef logic [phase_bits-1:0] phase_t;

	logic [6:0] note_q [n_voices];
	logic [6:0] vel_q [n_voices];
	phase_t inc_q [n_voices];
	phase_t phase_q [n_voices];
	logic [n_voices-1:0] active;
	logic [n_voices-1:0] released;  // held only by the pedal
	logic sustain;
	logic [idx_bits-1:0] free_idx;
	logic free_any;
	phase_t note_inc;
	logic note_on;
	logic note_off;
	logic pedal;

	// top octave increments, each lower octave is one more shift right
	function automatic phase_t semitone_inc(input logic [6:0] note);
		logic [3:0] octave;
		logic [3:0] semi;
		phase_t base;
		octave = 4'(note / 7'd12);
		semi = 4'(note % 7'd12);
		case (semi)
			4'd0: base = phase_t'(3512);
			4'd1: base = phase_t'(3721);
			4'd2: base = phase_t'(3942);
			4'd3: base = phase_t'(4177);
			4'd4: base = phase_t'(4425);
			4'd5: base = phase_t'(4688);
			4'd6: base = phase_t'(4967);
			4'd7: base = phase_t'(5262);
			4'd8: base = phase_t'(5575);
			4'd9: base = phase_t'(5906);
			4'd10: base = phase_t'(6258);
			default: base = phase_t'(6630);
		endcase
		return base >> (4'd10 - octave);
	endfunction

	assign note_on = msg_valid && (msg.kind == msg_note_on);
	assign note_off = msg_valid && (msg.kind == msg_note_off);
	assign pedal = msg_valid && (msg.kind == msg_control) &&
		(msg.note == 7'(sustain_controller));
	assign note_inc = semitone_inc(msg.note);

	always_comb begin
		free_any = 1'b0;
		free_idx = '0;
		for (int i = n_voices - 1; i >= 0; i--) begin
			if (!active[i]) begin
				free_any = 1'b1;
				free_idx = idx_bits'(i);
			end
		end
	end

	// ********************
	// voice state
	// ********************

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			active <= '0;
			released <= '0;
			sustain <= 1'b0;
			for (int i = 0; i < n_voices; i++)
				phase_q[i] <= '0;
		end else if (en) begin
			for (int i = 0; i < n_voices; i++) begin
				if (phase_step && active[i])
					phase_q[i] <= phase_q[i] + inc_q[i];
				if (note_off && active[i] && (note_q[i] == msg.note)) begin
					if (sustain)
						released[i] <= 1'b1;
					else
						active[i] <= 1'b0;
				end
				// pedal up ends every note that was let go while it was down
				if (pedal && (msg.value < 7'(sustain_threshold)) && released[i]) begin
					active[i] <= 1'b0;
					released[i] <= 1'b0;
				end
			end
			if (pedal)
				sustain <= (msg.value >= 7'(sustain_threshold));
			if (note_on && free_any) begin  // no free voice drops the note
				active[free_idx] <= 1'b1;
				released[free_idx] <= 1'b0;
				phase_q[free_idx] <= '0;
			end
			if (clear) begin
				active <= '0;
				released <= '0;
			end
		end
	end

	always_ff @(posedge MHz10) begin
		if (en && note_on && free_any) begin
			note_q[free_idx] <= msg.note;
			vel_q[free_idx] <= msg.value;
			inc_q[free_idx] <= note_inc;
		end
	end

	always_comb begin
		for (int i = 0; i < n_voices; i++) begin
			voices[i].active = active[i];
			voices[i].phase = phase_q[i][phase_bits-1 -: wave_bits];
			voices[i].velocity = vel_q[i];
		end
	end

endmodule

// File: mixer/mix_sequencer.sv
`timescale 1ns/1ps

module mix_sequencer import synth_pkg::*; #(
	parameter int n_voices = 8,
	parameter int samp_div = 64
) (
	input logic MHz10,
	input logic nrst,
	input logic en,
	input logic wave_mode_pb,
	input voice_t [n_voices-1:0] voices,
	output logic phase_step,
	output sample_t latch_output
);
	localparam int div_bits = $clog2(samp_div);
	localparam int idx_bits = (n_voices > 1) ? $clog2(n_voices) : 1;
	localparam logic [div_bits-1:0] div_last = div_bits'(samp_div - 1);
	localparam logic [idx_bits-1:0] idx_last = idx_bits'(n_voices - 1);

	logic [div_bits-1:0] div_cnt;
	logic [idx_bits-1:0] voice_idx;
	logic busy;  // a pass over the voices is running
	logic last_voice;
	sample_t sum;
	sample_t sum_next;
	logic [2:0] pb_sync;
	logic pb_rise;
	wave_mode_e wave_mode;
	voice_t cur;
	logic [wave_bits-1:0] shaped;
	logic [wave_bits+6:0] product;
	logic [wave_bits-1:0] contrib;

	// ********************
	// sample tick
	// ********************

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			div_cnt <= '0;
			phase_step <= 1'b0;
		end else if (en) begin
			phase_step <= (div_cnt == div_last);
			div_cnt <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;
		end
	end

	// button goes through two sync flops, the third finds the edge
	assign pb_rise = pb_sync[1] & ~pb_sync[2];

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			pb_sync <= '0;
			wave_mode <= wave_square;
		end else if (en) begin
			pb_sync <= {pb_sync[1:0], wave_mode_pb};
			if (pb_rise) begin
				case (wave_mode)
					wave_square: wave_mode <= wave_saw;
					wave_saw: wave_mode <= wave_triangle;
					default: wave_mode <= wave_square;
				endcase
			end
		end
	end

	// ********************
	// shaper and scaling
	// ********************

	assign cur = voices[voice_idx];

	always_comb begin
		case (wave_mode)
			wave_saw: shaped = cur.phase;
			wave_triangle: begin
				// 2*(255-p) is the inverted phase shifted up one
				if (cur.phase[wave_bits-1])
					shaped = {~cur.phase[wave_bits-2:0], 1'b0};
				else
					shaped = {cur.phase[wave_bits-2:0], 1'b0};
			end
			default: shaped = {wave_bits{cur.phase[wave_bits-1]}};
		endcase
	end

	assign product = shaped * cur.velocity;
	assign contrib = cur.active ? product[wave_bits+6:7] : '0;
	assign sum_next = sum + sample_t'(contrib);
	assign last_voice = (voice_idx == idx_last);

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			busy <= 1'b0;
			voice_idx <= '0;
			sum <= '0;
			latch_output <= '0;
		end else if (en) begin
			if (phase_step) begin
				sum <= '0;
				voice_idx <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				sum <= sum_next;
				voice_idx <= voice_idx + 1'b1;
				if (last_voice) begin
					busy <= 1'b0;
					latch_output <= sum_next;  // includes the last voice
				end
			end
		end
	end

endmodule

// File: source/poly_synth.sv
`timescale 1ns/1ps

module poly_synth import synth_pkg::*; #(
	parameter int n_voices = 8,
	parameter int clks_per_bit = 16,
	parameter int samp_div = 64
) (
	input logic MHz10,
	input logic nrst,
	input logic en,
	input logic ser_in,
	input logic wave_mode_pb,
	input logic clear,
	output sample_t latch_output
);
	logic [7:0] rx_data;
	logic rx_done;
	midi_msg_t msg;
	logic msg_valid;
	voice_t [n_voices-1:0] voices;
	logic phase_step;  // sample tick from the mixer back to the voices

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) uart_rx_inst (
		.MHz10(MHz10),
		.nrst(nrst),
		.en(en),
		.ser_in(ser_in),
		.data(rx_data),
		.done(rx_done)
	);

	midi_decoder midi_decoder_inst (
		.MHz10(MHz10),
		.nrst(nrst),
		.en(en),
		.data(rx_data),
		.done(rx_done),
		.msg(msg),
		.msg_valid(msg_valid)
	);

	voice_bank #(
		.n_voices(n_voices)
	) voice_bank_inst (
		.MHz10(MHz10),
		.nrst(nrst),
		.en(en),
		.clear(clear),
		.msg(msg),
		.msg_valid(msg_valid),
		.phase_step(phase_step),
		.voices(voices)
	);

	mix_sequencer #(
		.n_voices(n_voices),
		.samp_div(samp_div)
	) mix_sequencer_inst (
		.MHz10(MHz10),
		.nrst(nrst),
		.en(en),
		.wave_mode_pb(wave_mode_pb),
		.voices(voices),
		.phase_step(phase_step),
		.latch_output(latch_output)
	);

endmodule

// File: test/tb_poly_synth.sv
`timescale 1ns/1ps

module tb_poly_synth import synth_pkg::*; ();
	localparam int n_voices = 8;
	localparam int clks_per_bit = 16;
	localparam int samp_div = 64;
	localparam int clk_period = 100;
	localparam int max_steps = 16;
	localparam int max_msgs = 7;
	localparam int sustain_cc = 64;  // controller number of the sustain pedal
	localparam int pedal_down = 64;
	localparam int top_octave [12] = '{3512, 3721, 3942, 4177, 4425, 4688,
		4967, 5262, 5575, 5906, 6258, 6630};

	logic MHz10;
	logic nrst;
	logic en;
	logic ser_in;
	logic wave_mode_pb;
	logic clear;
	sample_t latch_output;

	// stimulus table, one row per step
	logic [23:0] tbl_msg [max_steps][max_msgs];
	int tbl_nmsg [max_steps];
	int tbl_presses [max_steps];
	bit tbl_clear [max_steps];
	int tbl_voices [max_steps];
	wave_mode_e tbl_mode [max_steps];
	int tbl_samples [max_steps];
	int n_steps;
	bit table_ready;

	bit m_active [n_voices];
	bit m_released [n_voices];
	logic [6:0] m_note [n_voices];
	logic [6:0] m_vel [n_voices];
	logic [phase_bits-1:0] m_inc [n_voices];
	logic [phase_bits-1:0] m_phase [n_voices];
	bit m_sustain;
	wave_mode_e m_mode;
	int cyc;  // falling edges since reset was released
	int seed;

	poly_synth #(
		.n_voices(n_voices),
		.clks_per_bit(clks_per_bit),
		.samp_div(samp_div)
	) poly_synth_inst (
		.MHz10(MHz10),
		.nrst(nrst),
		.en(en),
		.ser_in(ser_in),
		.wave_mode_pb(wave_mode_pb),
		.clear(clear),
		.latch_output(latch_output)
	);

	initial begin
		MHz10 = 1'b0;
		forever #(clk_period / 2) MHz10 = ~MHz10;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_sample(input sample_t actual, input sample_t expected);
		if (actual !== expected)
			abort_run($sformatf("** Error latch_output: got 0x%h, expected 0x%h at %0t",
				actual, expected, $time));
	endtask

	task automatic check_mode(input wave_mode_e actual, input wave_mode_e expected);
		if (actual !== expected)
			abort_run($sformatf("** Error wave_mode: got 0x%h, expected 0x%h at %0t",
				actual, expected, $time));
	endtask

	// ********************
	// reference model
	// ********************

	function automatic logic [23:0] midi_bytes(input logic [7:0] status, input logic [6:0] a,
		input logic [6:0] b);
		return {status, 1'b0, a, 1'b0, b};
	endfunction

	function automatic logic [phase_bits-1:0] note_step(input logic [6:0] note);
		int octave;
		int semi;
		octave = int'(note) / 12;
		semi = int'(note) % 12;
		return phase_bits'(top_octave[semi] >> (10 - octave));
	endfunction

	function automatic logic [7:0] wave_of(input wave_mode_e mode, input logic [7:0] p);
		case (mode)
			wave_saw: return p;
			wave_triangle: return (p < 8'd128) ? 8'(2 * int'(p)) : 8'(2 * (255 - int'(p)));
			default: return (p >= 8'd128) ? 8'hff : 8'h00;
		endcase
	endfunction

	function automatic sample_t model_sum(input wave_mode_e mode);
		sample_t acc;
		int prod;
		acc = '0;
		for (int i = 0; i < n_voices; i++) begin
			if (m_active[i]) begin
				prod = int'(wave_of(mode, m_phase[i][phase_bits-1 -: 8])) * int'(m_vel[i]);
				acc = acc + sample_t'(prod >> 7);
			end
		end
		return acc;
	endfunction

	// the mode whose waveform explains the sample, the current one first
	function automatic wave_mode_e infer_mode(input sample_t seen, input wave_mode_e hint);
		wave_mode_e mode;
		if (model_sum(hint) == seen)
			return hint;
		for (int k = 0; k < 3; k++) begin
			mode = wave_mode_e'(2'(k));
			if (model_sum(mode) == seen)
				return mode;
		end
		return hint;
	endfunction

	function automatic int count_active();
		int n;
		n = 0;
		for (int i = 0; i < n_voices; i++)
			n += int'(m_active[i]);
		return n;
	endfunction

	task automatic apply_msg(input logic [23:0] m);
		logic [3:0] kind;
		logic [6:0] a;
		logic [6:0] b;
		int slot;
		kind = m[23:20];
		a = m[14:8];
		b = m[6:0];
		slot = -1;
		if (kind == 4'h9 && b != 7'd0) begin
			for (int i = n_voices - 1; i >= 0; i--)
				if (!m_active[i])
					slot = i;
			if (slot >= 0) begin  // lowest free voice, or the note is lost
				m_active[slot] = 1'b1;
				m_released[slot] = 1'b0;
				m_note[slot] = a;
				m_vel[slot] = b;
				m_inc[slot] = note_step(a);
				m_phase[slot] = '0;
			end
		end else if (kind == 4'h9 || kind == 4'h8) begin
			for (int i = 0; i < n_voices; i++) begin
				if (m_active[i] && m_note[i] == a) begin
					if (m_sustain)
						m_released[i] = 1'b1;
					else
						m_active[i] = 1'b0;
				end
			end
		end else if (kind == 4'hb && int'(a) == sustain_cc) begin
			m_sustain = (int'(b) >= pedal_down);
			for (int i = 0; i < n_voices; i++) begin
				if (!m_sustain && m_released[i]) begin
					m_active[i] = 1'b0;
					m_released[i] = 1'b0;
				end
			end
		end
	endtask

	// ********************
	// timing and drivers
	// ********************

	task automatic step();
		@(negedge MHz10);
		cyc++;
		if (cyc > samp_div && (cyc - 1) % samp_div == 0) begin  // rising edge just took the tick
			for (int i = 0; i < n_voices; i++)
				if (m_active[i])
					m_phase[i] = m_phase[i] + m_inc[i];
		end
	endtask

	task automatic wait_sample();
		step();
		while (cyc < samp_div || (cyc - n_voices - 1) % samp_div != 0)
			step();
	endtask

	task automatic align();
		while (cyc % samp_div != 1)
			step();
	endtask

	task automatic send_byte(input logic [7:0] b);
		ser_in = 1'b0;
		repeat (clks_per_bit) step();
		for (int i = 0; i < 8; i++) begin
			ser_in = b[i];
			repeat (clks_per_bit) step();
		end
		ser_in = 1'b1;
		repeat (clks_per_bit) step();
	endtask

	// starting right after a tick puts the decoded message mid-period
	task automatic send_msg(input logic [23:0] m);
		align();
		send_byte(m[23:16]);
		send_byte(m[15:8]);
		send_byte(m[7:0]);
		apply_msg(m);
	endtask

	task automatic press_button();
		wave_mode_pb = 1'b1;
		repeat (4) step();
		wave_mode_pb = 1'b0;
		repeat (4) step();
		case (m_mode)
			wave_square: m_mode = wave_saw;
			wave_saw: m_mode = wave_triangle;
			default: m_mode = wave_square;
		endcase
	endtask

	task automatic pulse_clear();
		clear = 1'b1;
		step();
		clear = 1'b0;
		for (int i = 0; i < n_voices; i++) begin
			m_active[i] = 1'b0;
			m_released[i] = 1'b0;
		end
	endtask

	// ********************
	// table and main loop
	// ********************

	task automatic new_step(input int samples, input int presses, input bit clr,
		input int voices, input wave_mode_e mode);
		tbl_nmsg[n_steps] = 0;
		tbl_samples[n_steps] = samples;
		tbl_presses[n_steps] = presses;
		tbl_clear[n_steps] = clr;
		tbl_voices[n_steps] = voices;
		tbl_mode[n_steps] = mode;
		n_steps++;
	endtask

	task automatic push_msg(input logic [23:0] m);
		tbl_msg[n_steps - 1][tbl_nmsg[n_steps - 1]] = m;
		tbl_nmsg[n_steps - 1]++;
	endtask

	task automatic build_table();
		logic [6:0] notes [10];
		logic [6:0] vels [10];
		for (int i = 0; i < 10; i++) begin
			notes[i] = 7'(110 - 4 * i - ($random(seed) & 3));  // distinct, high ones first
			vels[i] = 7'(64 + ($random(seed) & 63));
		end
		n_steps = 0;
		new_step(6, 0, 1'b0, 0, wave_square);
		new_step(24, 0, 1'b0, 1, wave_square);
		push_msg(midi_bytes(8'h90, notes[0], vels[0]));
		new_step(4, 0, 1'b0, 0, wave_square);
		push_msg(midi_bytes(8'h80, notes[0], 7'd64));
		new_step(8, 0, 1'b0, 1, wave_square);
		push_msg(midi_bytes(8'h90, notes[0], vels[1]));
		new_step(4, 0, 1'b0, 0, wave_square);
		push_msg(midi_bytes(8'h90, notes[0], 7'd0));
		new_step(16, 0, 1'b0, 2, wave_square);
		push_msg(midi_bytes(8'h90, notes[1], vels[1]));
		push_msg(midi_bytes(8'h93, notes[2], vels[2]));
		new_step(16, 0, 1'b0, 8, wave_square);  // the last of these finds no free voice
		for (int i = 3; i < 10; i++)
			push_msg(midi_bytes(8'h90, notes[i], vels[i]));
		new_step(8, 0, 1'b0, 8, wave_square);
		push_msg(midi_bytes(8'hb0, 7'(sustain_cc), 7'd127));
		push_msg(midi_bytes(8'h80, notes[1], 7'd64));
		new_step(8, 0, 1'b0, 7, wave_square);
		push_msg(midi_bytes(8'hb0, 7'(sustain_cc), 7'd0));
		new_step(16, 1, 1'b0, 7, wave_saw);
		new_step(16, 1, 1'b0, 7, wave_triangle);
		new_step(8, 1, 1'b0, 7, wave_square);
		new_step(4, 0, 1'b1, 0, wave_square);
	endtask

	task automatic run_step(input int s);
		bit heard;
		sample_t expected;
		heard = 1'b0;
		align();
		for (int m = 0; m < tbl_nmsg[s]; m++)
			send_msg(tbl_msg[s][m]);
		if (tbl_presses[s] > 0 || tbl_clear[s]) begin
			go_quiet();
			repeat (tbl_presses[s]) press_button();
			if (tbl_clear[s])
				pulse_clear();
		end
		if (count_active() != tbl_voices[s])
			abort_run($sformatf("step %0d leaves %0d voices in the model but the table expects %0d",
				s, count_active(), tbl_voices[s]));
		for (int k = 0; k < tbl_samples[s]; k++) begin
			wait_sample();
			expected = model_sum(m_mode);
			// the first sound tells which waveform the DUT is really playing
			if (!heard && latch_output != '0) begin
				heard = 1'b1;
				check_mode(infer_mode(latch_output, m_mode), tbl_mode[s]);
			end
			check_sample(latch_output, expected);
		end
	endtask

	// the button and clear change nothing while a pass is mixing
	task automatic go_quiet();
		while (cyc % samp_div != samp_div / 2)
			step();
	endtask

	initial begin
		int limit;
		wait (table_ready);
		limit = 2000;  // reset and spare cycles
		for (int s = 0; s < n_steps; s++)
			limit += tbl_nmsg[s] * (3 * 10 * clks_per_bit + samp_div) +
				(tbl_samples[s] + 3) * samp_div;
		#(limit * clk_period);
		abort_run($sformatf("simulation timed out after %0d clock cycles", limit));
	end

	initial begin
		nrst = 1'b0;
		en = 1'b1;
		ser_in = 1'b1;
		wave_mode_pb = 1'b0;
		clear = 1'b0;
		cyc = 0;
		seed = 63643;
		m_sustain = 1'b0;
		m_mode = wave_square;
		for (int i = 0; i < n_voices; i++) begin
			m_active[i] = 1'b0;
			m_released[i] = 1'b0;
			m_phase[i] = '0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (3) @(negedge MHz10);
		nrst = 1'b1;
		for (int s = 0; s < n_steps; s++)
			run_step(s);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: all.f
common/synth_pkg.sv
source/uart_rx.sv
midi/midi_decoder.sv
voice/voice_bank.sv
mixer/mix_sequencer.sv
source/poly_synth.sv
test/tb_poly_synth.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_poly_synth -f all.f -o tb_poly_synth
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_poly_synth
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
